//--- run_sim.sh
#!/bin/sh
# Build and run the region_replicate testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f \
    --top-module region_replicate_tb \
    -Mdir obj_dir -o region_replicate_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/region_replicate_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in simulator output"
    exit 1
fi

//--- sources.f
verilog/pipearch_pkg.sv
verilog/region_bram.sv
verilog/region_fifo.sv
verilog/region_replicate.sv
test/region_replicate_properties.sv
test/region_replicate_tb.sv

//--- test/region_replicate_properties.sv
`default_nettype none

module region_replicate_properties import pipearch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we [num_write_channels],
    input  region_sel_e wsel [num_write_channels],
    input  logic        re [num_read_channels],
    input  region_sel_e rsel [num_read_channels],
    input  logic        mem_re [num_read_channels],
    input  logic        rvalid [num_read_channels],
    input  logic        empty [num_read_channels]
);
    timeunit 1ns;
    timeprecision 100ps;

    // Channel 1 loses silently when both hit one region
    write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(we[0] && we[1] && ((wsel[0] & wsel[1]) != 2'b00)))
        else $error("Both write channels target the same region");

    genvar r;
    generate
        for (r = 0; r < num_read_channels; r++) begin : gen_reader
            // A queue read of an empty copy stays silent
            valid_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
                rvalid[r] |-> $past(re[r] && (rsel[r] == REGION_MEM
                    || (rsel[r] == REGION_FIFO && !empty[r]))))
                else $error("rvalid on reader %0d without a read the cycle before", r);

            // Memory never misses, so each read must come back
            mem_read_returns: assert property (@(posedge clk) disable iff (!rst_n)
                mem_re[r] |=> rvalid[r])
                else $error("Memory read on reader %0d gave no rvalid", r);
        end
    endgenerate

endmodule

bind region_replicate region_replicate_properties u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (we),
    .wsel   (wsel),
    .re     (re),
    .rsel   (rsel),
    .mem_re (mem_re),
    .rvalid (rvalid),
    .empty  (empty)
);

`default_nettype wire

//--- test/region_replicate_tb.sv
`default_nettype none

module region_replicate_tb import pipearch_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   rst_n;
    logic                   we [num_write_channels];
    region_sel_e            wsel [num_write_channels];
    logic [log2_depth-1:0]  waddr [num_write_channels];
    logic [data_width-1:0]  wdata [num_write_channels];
    logic                   re [num_read_channels];
    region_sel_e            rsel [num_read_channels];
    logic [log2_depth-1:0]  raddr [num_read_channels];
    logic [data_width-1:0]  rdata [num_read_channels];
    logic                   rvalid [num_read_channels];
    logic                   empty [num_read_channels];
    logic [count_width-1:0] count;
    logic                   almostfull;

    string stim_lines [$];
    int    num_lines = 0;

    // Expected fill level of each private queue copy
    int    occupancy [num_read_channels];
    logic  queue_write_pending;

    region_replicate u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (we),
        .wsel       (wsel),
        .waddr      (waddr),
        .wdata      (wdata),
        .almostfull (almostfull),
        .count      (count),
        .re         (re),
        .rsel       (rsel),
        .raddr      (raddr),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .empty      (empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare_word(input string name, input logic [data_width-1:0] exp_val,
                                input logic [data_width-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "data word mismatch");
        end
    endtask

    task automatic verify_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic match_count(input string name, input logic [count_width-1:0] exp_val,
                               input logic [count_width-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR at %0d ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    code;
        string line;
        fd = $fopen("test/region_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/region_stim.txt");
            $display("Simulation failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                stim_lines.push_back(line);
            end
        end
        $fclose(fd);
        if (stim_lines.size() == 0) begin
            $display("The stimulus file holds no vectors");
            $display("Simulation failed");
            $fatal(1, "empty stimulus");
        end
        num_lines = stim_lines.size();
    endtask

    // Copies take the registered write one edge late, reads act on this edge
    function automatic void predict_queues();
        logic write_now;
        logic push_ok;
        logic pop_ok;
        write_now = 1'b0;
        for (int w = 0; w < num_write_channels; w++) begin
            if (we[w] && wsel[w][1]) begin
                write_now = 1'b1;
            end
        end
        for (int r = 0; r < num_read_channels; r++) begin
            push_ok = queue_write_pending && (occupancy[r] < depth);   // Full drops it
            pop_ok = re[r] && rsel[r][1] && (occupancy[r] > 0);
            occupancy[r] = occupancy[r] + int'(push_ok) - int'(pop_ok);
        end
        queue_write_pending = write_now;
    endfunction

    // One line is one cycle, checked at the following falling edge
    task automatic run_vector(input int idx);
        int n;
        int wev [num_write_channels];
        int wsv [num_write_channels];
        int wav [num_write_channels];
        int wdv [num_write_channels];
        int rev [num_read_channels];
        int rsv [num_read_channels];
        int rav [num_read_channels];
        int xv [num_read_channels];
        int xd [num_read_channels];
        int xe;
        int xc;
        int xa;
        n = $sscanf(stim_lines[idx],
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            wev[0], wsv[0], wav[0], wdv[0], wev[1], wsv[1], wav[1], wdv[1],
            rev[0], rsv[0], rav[0], rev[1], rsv[1], rav[1], rev[2], rsv[2], rav[2],
            xv[0], xd[0], xv[1], xd[1], xv[2], xd[2], xe, xc, xa);
        if (n != 26) begin
            $display("Stimulus vector %0d has %0d fields instead of 26", idx, n);
            $display("Simulation failed");
            $fatal(1, "malformed stimulus");
        end
        for (int w = 0; w < num_write_channels; w++) begin
            we[w] = 1'(wev[w]);
            wsel[w] = region_sel_e'(2'(wsv[w]));
            waddr[w] = log2_depth'(wav[w]);
            wdata[w] = data_width'(wdv[w]);
        end
        for (int r = 0; r < num_read_channels; r++) begin
            re[r] = 1'(rev[r]);
            rsel[r] = region_sel_e'(2'(rsv[r]));
            raddr[r] = log2_depth'(rav[r]);
        end
        predict_queues();
        @(negedge clk);
        for (int r = 0; r < num_read_channels; r++) begin
            verify_flag($sformatf("rvalid[%0d]", r), 1'(xv[r]), rvalid[r]);
            if (xv[r] != 0) begin    // rdata only means something with rvalid
                compare_word($sformatf("rdata[%0d]", r), data_width'(xd[r]), rdata[r]);
            end
        end
        verify_flag("empty[0]", 1'(xe), empty[0]);
        for (int r = 1; r < num_read_channels; r++) begin
            verify_flag($sformatf("empty[%0d]", r), occupancy[r] == 0, empty[r]);
        end
        match_count("count", count_width'(xc), count);
        verify_flag("almostfull", 1'(xa), almostfull);
    endtask

    initial begin
        rst_n = 1'b0;
        queue_write_pending = 1'b0;
        for (int w = 0; w < num_write_channels; w++) begin
            we[w] = 1'b0;
            wsel[w] = REGION_NONE;
            waddr[w] = '0;
            wdata[w] = '0;
        end
        for (int r = 0; r < num_read_channels; r++) begin
            re[r] = 1'b0;
            rsel[r] = REGION_NONE;
            raddr[r] = '0;
            occupancy[r] = 0;
        end
        read_vectors();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_lines; i++) begin
            run_vector(i);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // Ends a run that stalls past reset and the last vector
    initial begin
        wait (num_lines > 0);
        #((num_lines + 20) * 4);
        $display("Watchdog expired after %0d cycles without the run finishing", num_lines + 20);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- test/region_stim.txt
# we0 wsel0 waddr0 wdata0 we1 wsel1 waddr1 wdata1  re0 rsel0 raddr0 re1 rsel1 raddr1 re2 rsel2 raddr2
# expect: rvalid0 rdata0 rvalid1 rdata1 rvalid2 rdata2 empty0 count almostfull, all hex
# after reset
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
# memory broadcast from writer 0
1 1 03 a5 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
1 1 04 3c 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
1 1 05 7e 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
0 0 00 00 0 0 00 00  1 1 03 1 1 03 1 1 04  1 a5 1 a5 1 3c 1 00 0
0 0 00 00 0 0 00 00  1 1 05 1 1 04 1 1 03  1 7e 1 3c 1 a5 1 00 0
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
# queue order, independent drain, reads while empty
1 2 00 11 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
1 2 00 22 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 01 0
1 2 00 33 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 02 0
0 0 00 00 0 0 00 00  1 2 00 0 0 00 0 0 00  1 11 0 00 0 00 0 02 0
0 0 00 00 0 0 00 00  1 2 00 1 2 00 0 0 00  1 22 1 11 0 00 0 01 0
0 0 00 00 0 0 00 00  1 2 00 0 0 00 1 2 00  1 33 0 00 1 11 1 00 0
0 0 00 00 0 0 00 00  1 2 00 1 2 00 0 0 00  0 00 1 22 0 00 1 00 0
0 0 00 00 0 0 00 00  0 0 00 1 2 00 1 2 00  0 00 1 33 1 22 1 00 0
0 0 00 00 0 0 00 00  0 0 00 1 2 00 1 2 00  0 00 0 00 1 33 1 00 0
# writer 0 on memory, writer 1 on queue
1 1 0a 5a 1 2 00 c1  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
1 1 0b 6b 1 2 00 c2  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 01 0
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 02 0
0 0 00 00 0 0 00 00  1 1 0a 1 1 0b 1 2 00  1 5a 1 6b 1 c1 0 02 0
0 0 00 00 0 0 00 00  1 2 00 1 2 00 1 1 0a  1 c1 1 c1 1 5a 0 01 0
0 0 00 00 0 0 00 00  1 2 00 1 2 00 1 2 00  1 c2 1 c2 1 c2 1 00 0
# one write into both regions
0 0 00 00 1 3 0c 9d  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 01 0
0 0 00 00 0 0 00 00  1 1 0c 1 2 00 1 1 0c  1 9d 1 9d 1 9d 0 01 0
0 0 00 00 0 0 00 00  1 2 00 0 0 00 1 2 00  1 9d 0 00 1 9d 1 00 0
# fill past depth, last two pushes are dropped
1 2 00 40 1 1 10 e0  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 1 00 0
1 2 00 41 1 1 11 e1  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 01 0
1 2 00 42 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 02 0
1 2 00 43 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 03 0
1 2 00 44 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 04 0
1 2 00 45 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 05 0
1 2 00 46 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 06 0
1 2 00 47 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 07 0
1 2 00 48 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 08 0
1 2 00 49 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 09 0
1 2 00 4a 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0a 0
1 2 00 4b 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0b 0
1 2 00 4c 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0c 0
1 2 00 4d 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0d 0
1 2 00 4e 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0e 0
1 2 00 4f 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 0f 0
1 2 00 50 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 10 0
1 2 00 51 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 11 0
1 2 00 52 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 12 0
1 2 00 53 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 13 0
1 2 00 54 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 14 0
1 2 00 55 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 15 0
1 2 00 56 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 16 0
1 2 00 57 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 17 0
1 2 00 58 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 18 0
1 2 00 59 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 19 0
1 2 00 5a 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1a 0
1 2 00 5b 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1b 0
1 2 00 5c 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1c 1
1 2 00 5d 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1d 1
1 2 00 5e 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1e 1
1 2 00 5f 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1f 1
1 2 00 60 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 20 1
1 2 00 61 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 20 1
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 20 1
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 20 1
# back-to-back reads on reader 1, reader 0 drains below almost-full
0 0 00 00 0 0 00 00  1 2 00 1 1 10 1 1 03  1 40 1 e0 1 a5 0 1f 1
0 0 00 00 0 0 00 00  1 2 00 1 1 11 0 0 00  1 41 1 e1 0 00 0 1e 1
0 0 00 00 0 0 00 00  1 2 00 1 2 00 0 0 00  1 42 1 40 0 00 0 1d 1
0 0 00 00 0 0 00 00  1 2 00 1 2 00 0 0 00  1 43 1 41 0 00 0 1c 1
0 0 00 00 0 0 00 00  1 2 00 1 1 0a 0 0 00  1 44 1 5a 0 00 0 1b 0
0 0 00 00 0 0 00 00  0 0 00 1 2 00 0 0 00  0 00 1 42 0 00 0 1b 0
0 0 00 00 0 0 00 00  0 0 00 0 0 00 0 0 00  0 00 0 00 0 00 0 1b 0

//--- verilog/pipearch_pkg.sv
`default_nettype none

package pipearch_pkg;

    // Storage geometry
    localparam int data_width = 8;
    localparam int log2_depth = 5;
    localparam int depth = 1 << log2_depth;
    localparam int count_width = log2_depth + 1;   // Holds 0 to depth inclusive

    // Channel counts
    localparam int num_write_channels = 2;
    localparam int num_read_channels = 3;

    // Almost-full asserts at depth minus this margin
    localparam int almost_full_margin = 4;

    // Bit 0 is the memory, bit 1 is the queue
    typedef enum logic [1:0] {
        REGION_NONE = 2'b00,
        REGION_MEM  = 2'b01,
        REGION_FIFO = 2'b10,
        REGION_BOTH = 2'b11
    } region_sel_e;

endpackage

`default_nettype wire

//--- verilog/region_bram.sv
`default_nettype none

module region_bram import pipearch_pkg::*; (
    input  logic                  clk,
    input  logic                  mem_we,
    input  logic [log2_depth-1:0] mem_waddr,
    input  logic [data_width-1:0] mem_wdata,
    input  logic                  mem_re,
    input  logic [log2_depth-1:0] mem_raddr,
    output logic [data_width-1:0] mem_rdata,
    output logic                  mem_rvalid
);

    logic [data_width-1:0] mem [depth];

    // Simple dual port, read returns the old word on an address collision
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (mem_re) begin
            mem_rdata <= mem[mem_raddr];
        end
    end

    // One-cycle valid pulse that follows the read strobe
    always_ff @(posedge clk) begin
        mem_rvalid <= mem_re;
    end

endmodule

`default_nettype wire

//--- verilog/region_fifo.sv
`default_nettype none

module region_fifo import pipearch_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fifo_we,
    input  logic [data_width-1:0]  fifo_wdata,
    input  logic                   fifo_re,
    output logic [data_width-1:0]  fifo_rdata,
    output logic                   fifo_rvalid,
    output logic                   fifo_empty,
    output logic [count_width-1:0] fifo_count,
    output logic                   fifo_almostfull
);

    logic [data_width-1:0] mem [depth];
    logic [log2_depth-1:0] wr_ptr;
    logic [log2_depth-1:0] rd_ptr;
    logic                  full;
    logic                  push;
    logic                  pop;

    // Flags come straight from the registered count
    assign full = (fifo_count == count_width'(depth));
    assign fifo_empty = (fifo_count == '0);
    assign fifo_almostfull = (fifo_count >= count_width'(depth - almost_full_margin));

    assign push = fifo_we && !full;    // Writes into a full queue are lost
    assign pop = fifo_re && !fifo_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
            fifo_rvalid <= 1'b0;
        end else begin
            fifo_rvalid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: fifo_count <= fifo_count + 1'b1;
                2'b01: fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // Storage and head word
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fifo_wdata;
        end
        if (pop) begin
            fifo_rdata <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/region_replicate.sv
`default_nettype none

module region_replicate import pipearch_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Write channels
    input  logic                   we [num_write_channels],
    input  region_sel_e            wsel [num_write_channels],
    input  logic [log2_depth-1:0]  waddr [num_write_channels],
    input  logic [data_width-1:0]  wdata [num_write_channels],
    output logic                   almostfull,
    output logic [count_width-1:0] count,

    // Read channels
    input  logic                   re [num_read_channels],
    input  region_sel_e            rsel [num_read_channels],
    input  logic [log2_depth-1:0]  raddr [num_read_channels],
    output logic [data_width-1:0]  rdata [num_read_channels],
    output logic                   rvalid [num_read_channels],
    output logic                   empty [num_read_channels]
);

    // Arbitrated write, before and after the register stage
    logic                   mem_we_d;
    logic [log2_depth-1:0]  mem_waddr_d;
    logic [data_width-1:0]  mem_wdata_d;
    logic                   fifo_we_d;
    logic [data_width-1:0]  fifo_wdata_d;

    logic                   mem_we_q;
    logic [log2_depth-1:0]  mem_waddr_q;
    logic [data_width-1:0]  mem_wdata_q;
    logic                   fifo_we_q;
    logic [data_width-1:0]  fifo_wdata_q;

    // Per copy read side
    logic                   mem_re [num_read_channels];
    logic [data_width-1:0]  mem_rdata [num_read_channels];
    logic                   mem_rvalid [num_read_channels];
    logic                   fifo_re [num_read_channels];
    logic [data_width-1:0]  fifo_rdata [num_read_channels];
    logic                   fifo_rvalid [num_read_channels];
    logic                   fifo_empty [num_read_channels];
    logic [count_width-1:0] fifo_count [num_read_channels];
    logic                   fifo_almostfull [num_read_channels];

    logic                   re_q [num_read_channels];
    region_sel_e            rsel_q [num_read_channels];

    // Fixed priority, lower channel index wins each region
    always_comb begin
        mem_we_d = 1'b0;
        mem_waddr_d = waddr[0];
        mem_wdata_d = wdata[0];
        fifo_we_d = 1'b0;
        fifo_wdata_d = wdata[0];
        for (int w = num_write_channels - 1; w >= 0; w--) begin
            if (we[w] && wsel[w][0]) begin
                mem_we_d = 1'b1;
                mem_waddr_d = waddr[w];
                mem_wdata_d = wdata[w];
            end
            if (we[w] && wsel[w][1]) begin
                fifo_we_d = 1'b1;
                fifo_wdata_d = wdata[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we_q <= 1'b0;
            fifo_we_q <= 1'b0;
        end else begin
            mem_we_q <= mem_we_d;
            fifo_we_q <= fifo_we_d;
        end
    end

    always_ff @(posedge clk) begin
        mem_waddr_q <= mem_waddr_d;
        mem_wdata_q <= mem_wdata_d;
        fifo_wdata_q <= fifo_wdata_d;
    end

    // One private copy of each region per reader
    genvar r;
    generate
        for (r = 0; r < num_read_channels; r++) begin : gen_copy
            assign mem_re[r] = re[r] && rsel[r][0];
            assign fifo_re[r] = re[r] && rsel[r][1];

            region_bram u_bram (
                .clk        (clk),
                .mem_we     (mem_we_q),
                .mem_waddr  (mem_waddr_q),
                .mem_wdata  (mem_wdata_q),
                .mem_re     (mem_re[r]),
                .mem_raddr  (raddr[r]),
                .mem_rdata  (mem_rdata[r]),
                .mem_rvalid (mem_rvalid[r])
            );

            region_fifo u_fifo (
                .clk             (clk),
                .rst_n           (rst_n),
                .fifo_we         (fifo_we_q),
                .fifo_wdata      (fifo_wdata_q),
                .fifo_re         (fifo_re[r]),
                .fifo_rdata      (fifo_rdata[r]),
                .fifo_rvalid     (fifo_rvalid[r]),
                .fifo_empty      (fifo_empty[r]),
                .fifo_count      (fifo_count[r]),
                .fifo_almostfull (fifo_almostfull[r])
            );

            // Track which region the in-flight read went to
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    re_q[r] <= 1'b0;
                    rsel_q[r] <= REGION_NONE;
                end else begin
                    re_q[r] <= re[r];
                    rsel_q[r] <= rsel[r];
                end
            end

            assign rvalid[r] = re_q[r]
                && ((rsel_q[r] == REGION_MEM && mem_rvalid[r])
                || (rsel_q[r] == REGION_FIFO && fifo_rvalid[r]));

            // Memory path has priority, queue word otherwise
            assign rdata[r] = (re_q[r] && rsel_q[r] == REGION_MEM && mem_rvalid[r])
                ? mem_rdata[r] : fifo_rdata[r];

            assign empty[r] = fifo_empty[r];
        end
    endgenerate

    // Writers see the fill level of copy 0
    assign count = fifo_count[0];
    assign almostfull = fifo_almostfull[0];

endmodule

`default_nettype wire
